//--- design/z80BusPkg.sv
// Z80 bus interface definitions

package z80BusPkg;

    // ------------------------------------------------------------
    // Machine cycle functions
    // ------------------------------------------------------------
    typedef enum logic [2:0] {
        FN_FETCH   = 3'd0,  // Opcode fetch (M1 cycle)
        FN_MREAD   = 3'd1,  // Memory read
        FN_MWRITE  = 3'd2,  // Memory write
        FN_IOREAD  = 3'd3,  // I/O read
        FN_IOWRITE = 3'd4,  // I/O write
        FN_INTR    = 3'd5   // Interrupt acknowledge
    } mcycleFn;

    // Longest machine cycle in T-states
    localparam int T_STATES = 6;

    // ------------------------------------------------------------
    // Last T-state number of each machine cycle
    // ------------------------------------------------------------
    function automatic logic [2:0] fnLength(input mcycleFn fn);
        case (fn)
            FN_FETCH:   fnLength = 3'd4;    // T1..T4
            FN_MREAD:   fnLength = 3'd3;    // T1..T3
            FN_MWRITE:  fnLength = 3'd3;
            FN_IOREAD:  fnLength = 3'd4;    // Includes the automatic wait state
            FN_IOWRITE: fnLength = 3'd4;
            FN_INTR:    fnLength = 3'd6;    // Two extra wait states plus refresh
            default:    fnLength = 3'd4;    // Unused encodings
        endcase
    endfunction

endpackage

//--- design/busSequencer.sv
// Machine cycle sequencer

module busSequencer (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             start,      // Request a machine cycle
    input  z80BusPkg::mcycleFn               cycleFn,    // Requested function
    input  logic                             holdReq,    // Repeat the current T-state
    output logic [z80BusPkg::T_STATES-1:0]   tState,     // One-hot T1..T6
    output logic                             phaseHi,    // First half of a T-state
    output z80BusPkg::mcycleFn               fnActive,   // Function in progress
    output logic                             busy,
    output logic                             cycleDone   // Last low half without a hold
);

    // One-hot code of T1
    localparam logic [z80BusPkg::T_STATES-1:0] T1_STATE = {
        {(z80BusPkg::T_STATES-1){1'b0}}, 1'b1
    };

    logic [2:0] lastIdx;    // Bit index of the final T-state
    logic       lastState;  // Currently in the final T-state

    // ------------------------------------------------------------
    // End of cycle detection
    // ------------------------------------------------------------
    assign lastIdx   = z80BusPkg::fnLength(fnActive) - 3'd1;
    assign lastState = tState[lastIdx];

    // Low half of the last T-state that is not being stretched
    assign cycleDone = busy & ~phaseHi & lastState & ~holdReq;

    // ------------------------------------------------------------
    // T-state and phase walk
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            busy     <= 1'b0;
            tState   <= '0;
            phaseHi  <= 1'b0;
            fnActive <= z80BusPkg::FN_FETCH;
        end else if (!busy) begin
            // A request while idle starts T1 on the next clock
            if (start) begin
                busy     <= 1'b1;
                tState   <= T1_STATE;
                phaseHi  <= 1'b1;
                fnActive <= cycleFn;
            end
        end else if (phaseHi) begin
            phaseHi <= 1'b0;                // Into the low half
        end else if (holdReq) begin
            phaseHi <= 1'b1;                // Same T-state again
        end else if (lastState) begin
            // Cycle complete
            busy   <= 1'b0;
            tState <= '0;
        end else begin
            tState  <= tState << 1;         // Next T-state
            phaseHi <= 1'b1;
        end
    end

endmodule

//--- design/pinControl.sv
// Pin strobe and pad control decode

module pinControl (
    input  logic                             clk,
    input  logic                             rst,
    input  logic                             mwait,        // WAIT pin
    input  logic                             busrq,        // BUSRQ pin
    input  logic [z80BusPkg::T_STATES-1:0]   tState,
    input  logic                             phaseHi,
    input  z80BusPkg::mcycleFn               fnActive,
    input  logic                             busy,
    output logic                             m1,           // Opcode fetch phase
    output logic                             mreq,         // Memory request
    output logic                             iorq,         // I/O request
    output logic                             rd,
    output logic                             wr,
    output logic                             rfsh,         // Refresh phase
    output logic                             busack,
    output logic                             busOe,        // Control pin drive enable
    output logic                             abOe,         // Address pad drive enable
    output logic                             abWr,         // Load address pad
    output logic                             abSelRefresh, // Address pad takes {I, R}
    output logic                             dbOe,         // Data pad drive enable
    output logic                             dbRdPin,      // Data pad loads from pin
    output logic                             dbWr,         // Data pad loads write data
    output logic                             dbRd,         // Data pad to readData
    output logic                             holdReq       // Stretch current T-state
);

    logic t1, t2, t3, t4, t5, t6;
    logic hi, lo;
    logic fFetch, fMRead, fMWrite, fIORead, fIOWrite, fIntr;
    logic waitT;        // Wait sampling T-state of the function
    logic lastT;        // Final T-state of the function
    logic waitLatch;
    logic busrqLatch;

    // ------------------------------------------------------------
    // T-state, phase and function decode
    // ------------------------------------------------------------
    assign t1 = tState[0];
    assign t2 = tState[1];
    assign t3 = tState[2];
    assign t4 = tState[3];
    assign t5 = tState[4];
    assign t6 = tState[5];

    assign hi = phaseHi;    // Stands in for clock high
    assign lo = ~phaseHi;

    // Function flags only while a cycle runs
    assign fFetch   = busy & (fnActive == z80BusPkg::FN_FETCH);
    assign fMRead   = busy & (fnActive == z80BusPkg::FN_MREAD);
    assign fMWrite  = busy & (fnActive == z80BusPkg::FN_MWRITE);
    assign fIORead  = busy & (fnActive == z80BusPkg::FN_IOREAD);
    assign fIOWrite = busy & (fnActive == z80BusPkg::FN_IOWRITE);
    assign fIntr    = busy & (fnActive == z80BusPkg::FN_INTR);

    // ------------------------------------------------------------
    // External strobes
    // ------------------------------------------------------------
    assign m1   = (fFetch & (t1 | t2)) |
                  (fIntr  & (t1 | t2 | t3 | t4));

    // Fetch has the opcode read then the refresh access
    assign mreq = (fFetch             & ((t1 & lo) | t2 | (t3 & lo) | (t4 & hi))) |
                  ((fMRead | fMWrite) & ((t1 & lo) | t2 | (t3 & hi))) |
                  (fIntr              & ((t5 & lo) | t6));

    assign iorq = ((fIORead | fIOWrite) & (t2 | t3 | (t4 & hi))) |
                  (fIntr                & ((t3 & lo) | t4));   // Vector read

    assign rd   = (fFetch  & ((t1 & lo) | t2)) |
                  (fMRead  & ((t1 & lo) | t2 | (t3 & hi))) |
                  (fIORead & (t2 | t3 | (t4 & hi)));

    assign wr   = (fMWrite  & ((t2 & lo) | (t3 & hi))) |   // Data settles for half a T
                  (fIOWrite & (t2 | t3 | (t4 & hi)));

    assign rfsh = (fFetch & (t3 | t4)) |
                  (fIntr  & (t5 | t6));

    // ------------------------------------------------------------
    // WAIT and BUSRQ sampling
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            waitLatch  <= 1'b0;
            busrqLatch <= 1'b0;
        end else begin
            busrqLatch <= busrq;                // Every clock
            if (phaseHi) begin
                waitLatch <= mwait;             // End of each high half
            end
        end
    end

    assign busack = busrqLatch;

    // Where WAIT is honoured per function
    assign waitT = ((fFetch | fMRead | fMWrite) & t2) |
                   ((fIORead | fIOWrite)        & t3) |
                   (fIntr                       & t4);

    // BUSRQ only takes effect in the last T-state
    assign lastT = ((fFetch | fIORead | fIOWrite) & t4) |
                   ((fMRead | fMWrite)            & t3) |
                   (fIntr                         & t6);

    assign holdReq = (waitLatch & waitT) | (busrqLatch & lastT);

    // ------------------------------------------------------------
    // Pad controls
    // ------------------------------------------------------------
    // Pins float in reset and while the bus is granted away
    assign busOe = ~(rst | busack);
    assign abOe  = ~(rst | busack);

    // Program address in T1, refresh address in fetch T3 and interrupt T5
    assign abSelRefresh = (fFetch & t3) | (fIntr & t5);
    assign abWr         = hi & ((busy & t1) | abSelRefresh);

    assign dbOe    = (fMWrite  & ((t1 & lo) | t2 | t3)) |
                     (fIOWrite & ((t1 & lo) | t2 | t3 | t4));

    assign dbWr    = (fMWrite | fIOWrite) & t1 & hi;

    // Capture pin data as the read strobe closes
    assign dbRdPin = (fFetch  & t2) |
                     (fMRead  & t3 & hi) |
                     (fIORead & t4 & hi) |
                     (fIntr   & t4 & lo);

    assign dbRd    = (fFetch  & t3) |
                     (fMRead  & t3 & lo) |
                     (fIORead & t4 & lo) |
                     (fIntr   & t5);

endmodule

//--- design/addressPad.sv
// Address pad latch

module addressPad #(
    parameter int ADDR_W = 16
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              abWr,          // Load enable
    input  logic              abSelRefresh,  // Take the refresh address
    input  logic [ADDR_W-1:0] addrIn,        // Program address
    input  logic [ADDR_W-1:0] refreshAddr,   // {I, R}
    output logic [ADDR_W-1:0] addrPin
);

    logic [ADDR_W-1:0] padSel;
    logic [ADDR_W-1:0] padLatch;

    assign padSel = abSelRefresh ? refreshAddr : addrIn;

    always_ff @(posedge clk) begin
        if (rst) begin
            padLatch <= '0;
        end else if (abWr) begin
            padLatch <= padSel;     // Held for the rest of the cycle
        end
    end

    // Open latch while loading
    assign addrPin = abWr ? padSel : padLatch;

endmodule

//--- design/dataPad.sv
// Data pad latch

module dataPad #(
    parameter int DATA_W = 8
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              dbWr,        // Load from internal write data
    input  logic              dbRdPin,     // Load from the pin
    input  logic              dbRd,        // Latch to readData
    input  logic [DATA_W-1:0] writeData,
    input  logic [DATA_W-1:0] dataPin,
    output logic [DATA_W-1:0] dataPinOut,  // Value driven when dbOe
    output logic [DATA_W-1:0] readData
);

    logic [DATA_W-1:0] padLatch;

    // ------------------------------------------------------------
    // Pad latch shared by both directions
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            padLatch <= '0;
        end else if (dbWr) begin
            padLatch <= writeData;
        end else if (dbRdPin) begin
            padLatch <= dataPin;    // Sampled at the end of the read window
        end
    end

    assign dataPinOut = dbWr ? writeData : padLatch;   // Transparent while loading

    // Read-back to the internal side
    always_ff @(posedge clk) begin
        if (rst) begin
            readData <= '0;
        end else if (dbRd) begin
            readData <= padLatch;
        end
    end

endmodule

//--- design/refreshCounter.sv
// Refresh register R

module refreshCounter (
    input  logic               clk,
    input  logic               rst,
    input  logic               cycleDone,
    input  z80BusPkg::mcycleFn fnActive,
    output logic [7:0]         rReg
);

    logic stepR;    // Fetch or interrupt cycle just finished

    assign stepR = cycleDone &
                   ((fnActive == z80BusPkg::FN_FETCH) | (fnActive == z80BusPkg::FN_INTR));

    always_ff @(posedge clk) begin
        if (rst) begin
            rReg <= 8'h00;
        end else if (stepR) begin
            // Low 7 bits wrap and bit 7 is kept
            rReg <= {rReg[7], rReg[6:0] + 7'd1};
        end
    end

endmodule

//--- design/z80BusTop.sv
// Z80 external bus interface

module z80BusTop #(
    parameter int ADDR_W = 16,
    parameter int DATA_W = 8
) (
    input  logic               clk,
    input  logic               rst,
    input  logic               start,
    input  z80BusPkg::mcycleFn cycleFn,
    input  logic [ADDR_W-1:0]  addrIn,
    input  logic [DATA_W-1:0]  writeData,
    input  logic [7:0]         iReg,       // Interrupt vector base
    input  logic               mwait,
    input  logic               busrq,
    input  logic [DATA_W-1:0]  dataPin,
    output logic [ADDR_W-1:0]  addrPin,
    output logic               abOe,
    output logic [DATA_W-1:0]  dataPinOut,
    output logic               dbOe,
    output logic [DATA_W-1:0]  readData,
    output logic               m1,
    output logic               mreq,
    output logic               iorq,
    output logic               rd,
    output logic               wr,
    output logic               rfsh,
    output logic               busack,
    output logic               busOe,
    output logic               busy,
    output logic               cycleDone
);

    // ------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------
    logic [z80BusPkg::T_STATES-1:0] tState;
    logic                           phaseHi;
    z80BusPkg::mcycleFn             fnActive;
    logic                           holdReq;
    logic                           abWr;
    logic                           abSelRefresh;
    logic                           dbRdPin;
    logic                           dbWr;
    logic                           dbRd;
    logic [7:0]                     rReg;
    logic [ADDR_W-1:0]              refreshAddr;

    // Refresh address is I in the high byte and R in the low byte
    assign refreshAddr = ADDR_W'({iReg, rReg});

    busSequencer busSequencer_i (
        .clk       (clk),
        .rst       (rst),
        .start     (start),
        .cycleFn   (cycleFn),
        .holdReq   (holdReq),
        .tState    (tState),
        .phaseHi   (phaseHi),
        .fnActive  (fnActive),
        .busy      (busy),
        .cycleDone (cycleDone)
    );

    pinControl pinControl_i (
        .clk          (clk),
        .rst          (rst),
        .mwait        (mwait),
        .busrq        (busrq),
        .tState       (tState),
        .phaseHi      (phaseHi),
        .fnActive     (fnActive),
        .busy         (busy),
        .m1           (m1),
        .mreq         (mreq),
        .iorq         (iorq),
        .rd           (rd),
        .wr           (wr),
        .rfsh         (rfsh),
        .busack       (busack),
        .busOe        (busOe),
        .abOe         (abOe),
        .abWr         (abWr),
        .abSelRefresh (abSelRefresh),
        .dbOe         (dbOe),
        .dbRdPin      (dbRdPin),
        .dbWr         (dbWr),
        .dbRd         (dbRd),
        .holdReq      (holdReq)
    );

    // ------------------------------------------------------------
    // Pads and refresh
    // ------------------------------------------------------------
    addressPad #(.ADDR_W(ADDR_W)) addressPad_i (
        .clk          (clk),
        .rst          (rst),
        .abWr         (abWr),
        .abSelRefresh (abSelRefresh),
        .addrIn       (addrIn),
        .refreshAddr  (refreshAddr),
        .addrPin      (addrPin)
    );

    dataPad #(.DATA_W(DATA_W)) dataPad_i (
        .clk        (clk),
        .rst        (rst),
        .dbWr       (dbWr),
        .dbRdPin    (dbRdPin),
        .dbRd       (dbRd),
        .writeData  (writeData),
        .dataPin    (dataPin),
        .dataPinOut (dataPinOut),
        .readData   (readData)
    );

    refreshCounter refreshCounter_i (
        .clk       (clk),
        .rst       (rst),
        .cycleDone (cycleDone),
        .fnActive  (fnActive),
        .rReg      (rReg)
    );

endmodule

//--- bench/z80BusTb.sv
// Z80 bus interface testbench

module z80BusTb;

    logic               clk = 1'b0;
    logic               rst;
    logic               start;
    z80BusPkg::mcycleFn cycleFn;
    logic [15:0]        addrIn;
    logic [7:0]         writeData;
    logic [7:0]         iReg;
    logic               mwait;
    logic               busrq;
    logic [7:0]         dataPin;
    logic [15:0]        addrPin;
    logic [7:0]         dataPinOut;
    logic [7:0]         readData;
    logic abOe, dbOe, m1, mreq, iorq, rd, wr, rfsh, busack, busOe, busy, cycleDone;

    // Strobe windows of 12 bits each with bit 0 the T1 high half and bit 11 the T6 low half
    // Order {m1, mreq, iorq, rd, wr, rfsh, dbOe}
    localparam logic [83:0] W_FETCH  =
        {12'h00F, 12'h06E, 12'h000, 12'h00E, 12'h000, 12'h0F0, 12'h000};
    localparam logic [83:0] W_MREAD  =
        {12'h000, 12'h01E, 12'h000, 12'h01E, 12'h000, 12'h000, 12'h000};
    localparam logic [83:0] W_MWRITE =
        {12'h000, 12'h01E, 12'h000, 12'h000, 12'h018, 12'h000, 12'h03E};
    localparam logic [83:0] W_IORD   =
        {12'h000, 12'h000, 12'h07C, 12'h07C, 12'h000, 12'h000, 12'h000};
    localparam logic [83:0] W_IOWR   =
        {12'h000, 12'h000, 12'h07C, 12'h000, 12'h07C, 12'h000, 12'h0FE};
    localparam logic [83:0] W_INTR   =
        {12'h0FF, 12'hE00, 12'h0E0, 12'h000, 12'h000, 12'hF00, 12'h000};
    localparam int WRAP_FETCHES = 130;      // Enough to wrap the 7-bit R

    // Stimulus table
    z80BusPkg::mcycleFn rowFn[$];
    logic [15:0]        rowAddr[$];
    logic [7:0]         rowWdata[$];
    int                 rowWaits[$];
    int                 rowHolds[$];        // T-states held by BUSRQ
    bit                 rowPoke[$];         // Extra start while busy
    logic [83:0]        rowWin[$];

    logic [7:0]  mem[256];                  // Memory/IO model contents
    logic [31:0] rndState;
    logic [7:0]  rModel;
    int          rSteps;                    // Fetch and interrupt cycles so far
    int          budget;

    z80BusTop z80BusTop_i (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // Data the bus model returns for an address
    function automatic logic [7:0] modelData(input logic [15:0] a);
        return mem[a[7:0]] ^ a[15:8];
    endfunction

    // T-state in which WAIT is honoured
    function automatic int waitStateOf(input z80BusPkg::mcycleFn fn);
        case (fn)
            z80BusPkg::FN_IOREAD, z80BusPkg::FN_IOWRITE: return 3;
            z80BusPkg::FN_INTR:                          return 4;
            default:                                     return 2;
        endcase
    endfunction

    // Number of T-states in each machine cycle
    function automatic int cycleTStates(input z80BusPkg::mcycleFn fn);
        case (fn)
            z80BusPkg::FN_MREAD, z80BusPkg::FN_MWRITE: return 3;
            z80BusPkg::FN_INTR:                        return 6;
            default:                                   return 4;
        endcase
    endfunction

    task automatic addRow(input z80BusPkg::mcycleFn fn, input logic [15:0] a,
                          input logic [7:0] d, input int w, input int h,
                          input bit p, input logic [83:0] win);
        rowFn.push_back(fn);
        rowAddr.push_back(a);
        rowWdata.push_back(d);
        rowWaits.push_back(w);
        rowHolds.push_back(h);
        rowPoke.push_back(p);
        rowWin.push_back(win);
    endtask

    task automatic checkVal(input string what, input logic [31:0] expV, input logic [31:0] actV);
        assert (expV === actV) else begin
            $display("CHECK FAILED %s expected %0h actual %0h", what, expV, actV);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    // ------------------------------------------------------------
    // One machine cycle with its own T-state model
    // ------------------------------------------------------------
    task automatic runCycle(input string name, input z80BusPkg::mcycleFn fn,
                            input logic [15:0] a, input logic [7:0] d, input int waits,
                            input int holds, input bit poke, input logic [83:0] win);
        int         len, waitT, t, h, clocks, waitsDone, holdsDone;
        bit         hi, done, wl, prevBus, drvWait, drvBus, holdW, holdB, refreshT, readWin;
        logic [6:0] expStrobe;
        logic [7:0] rdData;
        len = cycleTStates(fn);
        waitT = waitStateOf(fn);
        rdData = modelData(a);
        @(posedge clk);
        start <= 1'b1;
        cycleFn <= fn;
        addrIn <= a;
        writeData <= d;
        @(posedge clk);                     // DUT now in T1 high
        t = 1;
        hi = 1;
        done = 0;
        wl = 0;
        prevBus = 0;
        clocks = 0;
        waitsDone = 0;
        holdsDone = 0;
        while (!done) begin
            drvWait = hi && (t == waitT) && (waitsDone < waits);
            drvBus  = (t == len) && (holdsDone < holds);
            h = 2 * (t - 1) + (hi ? 0 : 1);
            for (int j = 0; j < 7; j++) expStrobe[j] = win[12 * j + h];
            // Valid data only inside the read strobe, the vector read for INTA
            readWin = (fn == z80BusPkg::FN_INTR) ? expStrobe[4] : expStrobe[3];
            mwait <= drvWait;
            busrq <= drvBus;
            start <= poke && (t == 2) && hi;    // Must be ignored
            dataPin <= readWin ? rdData : ~rdData;
            holdW = !hi && wl && (t == waitT);
            holdB = !hi && prevBus && (t == len);
            refreshT = ((fn == z80BusPkg::FN_FETCH) && (t == 3 || t == 4)) ||
                       ((fn == z80BusPkg::FN_INTR) && (t >= 5));
            @(negedge clk);
            checkVal({name, " busy"}, 1, 32'(busy));
            checkVal($sformatf("%s strobes T%0d hi=%0d", name, t, hi), 32'(expStrobe),
                     32'({m1, mreq, iorq, rd, wr, rfsh, dbOe}));
            checkVal({name, " busack"}, 32'(prevBus), 32'(busack));
            checkVal({name, " busOe"}, 32'(!prevBus), 32'(busOe));
            checkVal({name, " abOe"}, 32'(!prevBus), 32'(abOe));
            checkVal($sformatf("%s cycleDone T%0d", name, t),
                     32'(!hi && (t == len) && !holdW && !holdB), 32'(cycleDone));
            checkVal($sformatf("%s addrPin T%0d", name, t),
                     32'(refreshT ? {iReg, rModel} : a), 32'(addrPin));
            if (expStrobe[0]) checkVal({name, " dataPinOut"}, 32'(d), 32'(dataPinOut));
            @(posedge clk);
            clocks++;
            if (hi) wl = drvWait;           // WAIT sampled at end of high half
            prevBus = drvBus;
            if (hi) begin
                hi = 0;
            end else if (holdW || holdB) begin
                hi = 1;                     // Same T-state again
                waitsDone += int'(holdW);
                holdsDone += int'(holdB);
            end else if (t == len) begin
                done = 1;
            end else begin
                t++;
                hi = 1;
            end
        end
        start <= 1'b0;
        mwait <= 1'b0;
        busrq <= 1'b0;
        if (fn == z80BusPkg::FN_FETCH || fn == z80BusPkg::FN_INTR) begin
            rSteps++;
            rModel = {rModel[7], 7'(rSteps % 128)};   // R counts modulo 128
        end
        @(negedge clk);
        checkVal({name, " length"}, 2 * len + 2 * waits + 2 * holds, clocks);
        checkVal({name, " busy after end"}, 0, 32'(busy));
        if (fn inside {z80BusPkg::FN_FETCH, z80BusPkg::FN_MREAD,
                       z80BusPkg::FN_IOREAD, z80BusPkg::FN_INTR})
            checkVal({name, " readData"}, 32'(rdData), 32'(readData));
    endtask

    // ------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------
    initial begin
        #1;
        budget = 20 + WRAP_FETCHES * (8 + 20);
        foreach (rowFn[i])
            budget += 2 * int'(z80BusPkg::fnLength(rowFn[i])) + 2 * rowWaits[i] +
                      2 * rowHolds[i] + 20;
        repeat (budget) @(posedge clk);
        $display("Watchdog expired before the tests completed");
        $display("Simulation failed");
        $fatal(1);
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        addRow(z80BusPkg::FN_FETCH,   16'h0100, 8'h00, 0, 0, 0, W_FETCH);
        addRow(z80BusPkg::FN_MREAD,   16'h8F21, 8'h00, 0, 0, 0, W_MREAD);
        addRow(z80BusPkg::FN_MWRITE,  16'h4433, 8'h5A, 0, 0, 0, W_MWRITE);
        addRow(z80BusPkg::FN_IOREAD,  16'h12FE, 8'h00, 0, 0, 0, W_IORD);
        addRow(z80BusPkg::FN_IOWRITE, 16'h0077, 8'hC3, 0, 0, 0, W_IOWR);
        addRow(z80BusPkg::FN_INTR,    16'h0038, 8'h00, 0, 0, 0, W_INTR);
        addRow(z80BusPkg::FN_FETCH,   16'h2345, 8'h00, 2, 0, 1, W_FETCH);
        addRow(z80BusPkg::FN_MREAD,   16'hA0B1, 8'h00, 1, 0, 1, W_MREAD);
        addRow(z80BusPkg::FN_IOREAD,  16'h7F10, 8'h00, 3, 0, 0, W_IORD);
        addRow(z80BusPkg::FN_IOWRITE, 16'h5E5E, 8'h81, 0, 2, 0, W_IOWR);
        addRow(z80BusPkg::FN_MWRITE,  16'hFFFF, 8'h3D, 1, 1, 1, W_MWRITE);
        addRow(z80BusPkg::FN_INTR,    16'h0066, 8'h00, 1, 1, 0, W_INTR);
        rst = 1'b1;
        start = 1'b0;
        cycleFn = z80BusPkg::FN_FETCH;
        addrIn = '0;
        writeData = '0;
        iReg = 8'h9C;
        mwait = 1'b0;
        busrq = 1'b0;
        dataPin = '0;
        rModel = 8'h00;
        rSteps = 0;
        rndState = 32'h4ca5dcb2;
        for (int i = 0; i < 256; i++) begin
            rndState = xorshift(rndState);
            mem[i] = rndState[7:0];
        end
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkVal("reset strobes", 0, 32'({m1, mreq, iorq, rd, wr, rfsh, dbOe, busack}));
        checkVal("reset enables", 32'(2'b11), 32'({busOe, abOe}));
        checkVal("reset busy", 0, 32'({busy, cycleDone}));
        foreach (rowFn[i])
            runCycle($sformatf("row%0d", i), rowFn[i], rowAddr[i], rowWdata[i],
                     rowWaits[i], rowHolds[i], rowPoke[i], rowWin[i]);
        // Fetch run long enough to wrap R
        for (int k = 0; k < WRAP_FETCHES; k++) begin
            rndState = xorshift(rndState);
            runCycle($sformatf("wrap%0d", k), z80BusPkg::FN_FETCH, rndState[15:0],
                     8'h00, 0, 0, 0, W_FETCH);
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

//--- build.f
design/z80BusPkg.sv
design/busSequencer.sv
design/pinControl.sv
design/addressPad.sv
design/dataPad.sv
design/refreshCounter.sv
design/z80BusTop.sv
bench/z80BusTb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= z80BusTb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(BUILD_DIR)/V$(TOP):
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then exit 1; fi
	@grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
